// ==== hdl/dual_issue_pkg.sv ====
`default_nettype none

package dual_issue_pkg;

    localparam int XLEN       = 32;
    localparam int REG_AW     = 5;
    localparam int REG_NUM    = 32;
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = 3;
    localparam int ALU_OP_W   = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_NOR  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd10;
    localparam logic [ALU_OP_W-1:0] ALU_LUI  = 4'd11;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // same word seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [5:0]        op;
            logic [REG_AW-1:0] rs;
            logic [REG_AW-1:0] rt;
            logic [REG_AW-1:0] rd;
            logic [4:0]        shamt;
            logic [5:0]        funct;
        } r;
        struct packed {
            logic [5:0]        op;
            logic [REG_AW-1:0] rs;
            logic [REG_AW-1:0] rt;
            logic [15:0]       imm16;
        } i;
    } inst_u;

endpackage

`default_nettype wire

// ==== hdl/inst_fifo.sv ====
`default_nettype none

module inst_fifo (
    input  wire                                  clk,
    input  wire                                  rst_i,
    input  wire                                  push_i,
    input  wire  [dual_issue_pkg::XLEN-1:0]      push_data_i,
    input  wire  [1:0]                           pop_cnt_i,
    output logic [dual_issue_pkg::XLEN-1:0]      head0_o,
    output logic [dual_issue_pkg::XLEN-1:0]      head1_o,
    output logic [dual_issue_pkg::FIFO_AW:0]     count_o,
    output logic                                 full_o
);

    logic [dual_issue_pkg::XLEN-1:0]    mem [dual_issue_pkg::FIFO_DEPTH];
    logic [dual_issue_pkg::FIFO_AW-1:0] wptr;
    logic [dual_issue_pkg::FIFO_AW-1:0] rptr;
    logic [dual_issue_pkg::FIFO_AW-1:0] rptr_next;
    logic [dual_issue_pkg::FIFO_AW:0]   count;

    assign rptr_next = rptr + dual_issue_pkg::FIFO_AW'(1);

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wptr] <= push_data_i;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (push_i) begin
                wptr <= wptr + dual_issue_pkg::FIFO_AW'(1);
            end
            rptr  <= rptr + dual_issue_pkg::FIFO_AW'(pop_cnt_i);
            count <= count + (dual_issue_pkg::FIFO_AW + 1)'(push_i)
                           - (dual_issue_pkg::FIFO_AW + 1)'(pop_cnt_i);
        end
    end

    assign head0_o = mem[rptr];
    assign head1_o = mem[rptr_next];
    assign count_o = count;
    assign full_o  = (count == (dual_issue_pkg::FIFO_AW + 1)'(dual_issue_pkg::FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== hdl/decoder.sv ====
`default_nettype none

module decoder (
    input  wire dual_issue_pkg::inst_u               inst_i,
    output logic [dual_issue_pkg::REG_AW-1:0]        rs_o,
    output logic [dual_issue_pkg::REG_AW-1:0]        rt_o,
    output logic [dual_issue_pkg::REG_AW-1:0]        waddr_o,
    output logic                                     wen_o,
    output logic [dual_issue_pkg::ALU_OP_W-1:0]      aluop_o,
    output logic                                     sel_shamt_o,
    output logic                                     sel_imm_o,
    output logic [dual_issue_pkg::XLEN-1:0]          imm_o,
    output logic [4:0]                               shamt_o
);

    logic [dual_issue_pkg::REG_AW-1:0] dest;
    logic                              known;
    logic [dual_issue_pkg::XLEN-1:0]   imm_sext;
    logic [dual_issue_pkg::XLEN-1:0]   imm_zext;

    assign imm_sext = {{16{inst_i.i.imm16[15]}}, inst_i.i.imm16};
    assign imm_zext = {16'h0000, inst_i.i.imm16};

    always_comb begin
        aluop_o     = dual_issue_pkg::ALU_ADD;
        sel_shamt_o = 1'b0;
        sel_imm_o   = 1'b0;
        imm_o       = imm_zext;
        dest        = inst_i.i.rt;
        known       = 1'b1;
        if (inst_i.r.op == dual_issue_pkg::OP_RTYPE) begin
            dest = inst_i.r.rd;
            case (inst_i.r.funct)
                dual_issue_pkg::FN_ADDU: aluop_o = dual_issue_pkg::ALU_ADD;
                dual_issue_pkg::FN_SUBU: aluop_o = dual_issue_pkg::ALU_SUB;
                dual_issue_pkg::FN_AND:  aluop_o = dual_issue_pkg::ALU_AND;
                dual_issue_pkg::FN_OR:   aluop_o = dual_issue_pkg::ALU_OR;
                dual_issue_pkg::FN_XOR:  aluop_o = dual_issue_pkg::ALU_XOR;
                dual_issue_pkg::FN_NOR:  aluop_o = dual_issue_pkg::ALU_NOR;
                dual_issue_pkg::FN_SLT:  aluop_o = dual_issue_pkg::ALU_SLT;
                dual_issue_pkg::FN_SLTU: aluop_o = dual_issue_pkg::ALU_SLTU;
                dual_issue_pkg::FN_SLL:  aluop_o = dual_issue_pkg::ALU_SLL;
                dual_issue_pkg::FN_SRL:  aluop_o = dual_issue_pkg::ALU_SRL;
                dual_issue_pkg::FN_SRA:  aluop_o = dual_issue_pkg::ALU_SRA;
                default:                 known   = 1'b0;
            endcase
            // shifts take shamt in place of rs
            sel_shamt_o = (aluop_o == dual_issue_pkg::ALU_SLL)
                       || (aluop_o == dual_issue_pkg::ALU_SRL)
                       || (aluop_o == dual_issue_pkg::ALU_SRA);
        end else begin
            sel_imm_o = 1'b1;
            case (inst_i.i.op)
                dual_issue_pkg::OP_ADDIU: begin
                    aluop_o = dual_issue_pkg::ALU_ADD;
                    imm_o   = imm_sext;
                end
                dual_issue_pkg::OP_SLTI: begin
                    aluop_o = dual_issue_pkg::ALU_SLT;
                    imm_o   = imm_sext;
                end
                dual_issue_pkg::OP_ANDI: aluop_o = dual_issue_pkg::ALU_AND;
                dual_issue_pkg::OP_ORI:  aluop_o = dual_issue_pkg::ALU_OR;
                dual_issue_pkg::OP_XORI: aluop_o = dual_issue_pkg::ALU_XOR;
                dual_issue_pkg::OP_LUI:  aluop_o = dual_issue_pkg::ALU_LUI;
                default:                 known   = 1'b0;
            endcase
        end
    end

    assign rs_o    = inst_i.r.rs;
    assign rt_o    = inst_i.i.rt;
    assign shamt_o = inst_i.r.shamt;
    assign waddr_o = dest;
    // r0 is never written
    assign wen_o   = known && (dest != '0);

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
`default_nettype none

module regfile (
    input  wire                                  clk,
    input  wire                                  rst_i,
    input  wire  [dual_issue_pkg::REG_AW-1:0]    ra0_i,
    input  wire  [dual_issue_pkg::REG_AW-1:0]    ra1_i,
    input  wire  [dual_issue_pkg::REG_AW-1:0]    ra2_i,
    input  wire  [dual_issue_pkg::REG_AW-1:0]    ra3_i,
    input  wire                                  we0_i,
    input  wire  [dual_issue_pkg::REG_AW-1:0]    wa0_i,
    input  wire  [dual_issue_pkg::XLEN-1:0]      wd0_i,
    input  wire                                  we1_i,
    input  wire  [dual_issue_pkg::REG_AW-1:0]    wa1_i,
    input  wire  [dual_issue_pkg::XLEN-1:0]      wd1_i,
    output logic [dual_issue_pkg::XLEN-1:0]      rd0_o,
    output logic [dual_issue_pkg::XLEN-1:0]      rd1_o,
    output logic [dual_issue_pkg::XLEN-1:0]      rd2_o,
    output logic [dual_issue_pkg::XLEN-1:0]      rd3_o
);

    logic [dual_issue_pkg::XLEN-1:0] regs [dual_issue_pkg::REG_NUM];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < dual_issue_pkg::REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we0_i) begin
                regs[wa0_i] <= wd0_i;
            end
            // slave is younger, so its write lands last
            if (we1_i) begin
                regs[wa1_i] <= wd1_i;
            end
        end
    end

    assign rd0_o = (ra0_i == '0) ? '0 : regs[ra0_i];
    assign rd1_o = (ra1_i == '0) ? '0 : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : regs[ra2_i];
    assign rd3_o = (ra3_i == '0) ? '0 : regs[ra3_i];

endmodule

`default_nettype wire

// ==== hdl/forward_unit.sv ====
`default_nettype none

module forward_unit (
    input  wire  [dual_issue_pkg::REG_AW-1:0]    src0_i,
    input  wire  [dual_issue_pkg::REG_AW-1:0]    src1_i,
    input  wire  [dual_issue_pkg::REG_AW-1:0]    src2_i,
    input  wire  [dual_issue_pkg::REG_AW-1:0]    src3_i,
    input  wire  [dual_issue_pkg::XLEN-1:0]      rf0_i,
    input  wire  [dual_issue_pkg::XLEN-1:0]      rf1_i,
    input  wire  [dual_issue_pkg::XLEN-1:0]      rf2_i,
    input  wire  [dual_issue_pkg::XLEN-1:0]      rf3_i,
    input  wire                                  e_master_wen_i,
    input  wire  [dual_issue_pkg::REG_AW-1:0]    e_master_waddr_i,
    input  wire  [dual_issue_pkg::XLEN-1:0]      e_master_res_i,
    input  wire                                  e_slave_wen_i,
    input  wire  [dual_issue_pkg::REG_AW-1:0]    e_slave_waddr_i,
    input  wire  [dual_issue_pkg::XLEN-1:0]      e_slave_res_i,
    input  wire                                  w_master_wen_i,
    input  wire  [dual_issue_pkg::REG_AW-1:0]    w_master_waddr_i,
    input  wire  [dual_issue_pkg::XLEN-1:0]      w_master_res_i,
    input  wire                                  w_slave_wen_i,
    input  wire  [dual_issue_pkg::REG_AW-1:0]    w_slave_waddr_i,
    input  wire  [dual_issue_pkg::XLEN-1:0]      w_slave_res_i,
    output logic [dual_issue_pkg::XLEN-1:0]      val0_o,
    output logic [dual_issue_pkg::XLEN-1:0]      val1_o,
    output logic [dual_issue_pkg::XLEN-1:0]      val2_o,
    output logic [dual_issue_pkg::XLEN-1:0]      val3_o
);

    logic [dual_issue_pkg::REG_AW-1:0] src [4];
    logic [dual_issue_pkg::XLEN-1:0]   rf  [4];
    logic [dual_issue_pkg::XLEN-1:0]   val [4];

    assign src = '{src0_i, src1_i, src2_i, src3_i};
    assign rf  = '{rf0_i, rf1_i, rf2_i, rf3_i};

    // youngest producer first
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            if (src[k] == '0) begin
                val[k] = rf[k];
            end else if (e_slave_wen_i && (e_slave_waddr_i == src[k])) begin
                val[k] = e_slave_res_i;
            end else if (e_master_wen_i && (e_master_waddr_i == src[k])) begin
                val[k] = e_master_res_i;
            end else if (w_slave_wen_i && (w_slave_waddr_i == src[k])) begin
                val[k] = w_slave_res_i;
            end else if (w_master_wen_i && (w_master_waddr_i == src[k])) begin
                val[k] = w_master_res_i;
            end else begin
                val[k] = rf[k];
            end
        end
    end

    assign val0_o = val[0];
    assign val1_o = val[1];
    assign val2_o = val[2];
    assign val3_o = val[3];

endmodule

`default_nettype wire

// ==== hdl/issue_ctrl.sv ====
`default_nettype none

module issue_ctrl (
    input  wire  [dual_issue_pkg::FIFO_AW:0]     count_i,
    input  wire                                  master_wen_i,
    input  wire  [dual_issue_pkg::REG_AW-1:0]    master_waddr_i,
    input  wire  [dual_issue_pkg::REG_AW-1:0]    slave_rs_i,
    input  wire  [dual_issue_pkg::REG_AW-1:0]    slave_rt_i,
    output logic                                 master_issue_o,
    output logic                                 slave_issue_o,
    output logic [1:0]                           pop_cnt_o
);

    logic raw_hazard;

    // slave may not consume a result produced in the same pair
    assign raw_hazard = master_wen_i
                     && ((slave_rs_i == master_waddr_i) || (slave_rt_i == master_waddr_i));

    assign master_issue_o = (count_i != '0);
    assign slave_issue_o  = (count_i >= (dual_issue_pkg::FIFO_AW + 1)'(2)) && !raw_hazard;

    assign pop_cnt_o = {1'b0, master_issue_o} + {1'b0, slave_issue_o};

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`default_nettype none

module alu (
    input  wire  [dual_issue_pkg::ALU_OP_W-1:0]  aluop_i,
    input  wire  [dual_issue_pkg::XLEN-1:0]      a_i,
    input  wire  [dual_issue_pkg::XLEN-1:0]      b_i,
    output logic [dual_issue_pkg::XLEN-1:0]      y_o
);

    logic [4:0] sa;

    assign sa = a_i[4:0];

    always_comb begin
        case (aluop_i)
            dual_issue_pkg::ALU_ADD:  y_o = a_i + b_i;
            dual_issue_pkg::ALU_SUB:  y_o = a_i - b_i;
            dual_issue_pkg::ALU_AND:  y_o = a_i & b_i;
            dual_issue_pkg::ALU_OR:   y_o = a_i | b_i;
            dual_issue_pkg::ALU_XOR:  y_o = a_i ^ b_i;
            dual_issue_pkg::ALU_NOR:  y_o = ~(a_i | b_i);
            dual_issue_pkg::ALU_SLT:  y_o = dual_issue_pkg::XLEN'($signed(a_i) < $signed(b_i));
            dual_issue_pkg::ALU_SLTU: y_o = dual_issue_pkg::XLEN'(a_i < b_i);
            dual_issue_pkg::ALU_SLL:  y_o = b_i << sa;
            dual_issue_pkg::ALU_SRL:  y_o = b_i >> sa;
            dual_issue_pkg::ALU_SRA:  y_o = $signed(b_i) >>> sa;
            dual_issue_pkg::ALU_LUI:  y_o = {b_i[15:0], 16'h0000};
            default:                  y_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/datapath.sv ====
`default_nettype none

module datapath (
    input  wire                                  clk,
    input  wire                                  rst_i,
    input  wire                                  inst_valid_i,
    input  wire  [dual_issue_pkg::XLEN-1:0]      inst_i,
    output logic                                 inst_ready_o,
    output logic                                 wb_master_wen_o,
    output logic [dual_issue_pkg::REG_AW-1:0]    wb_master_waddr_o,
    output logic [dual_issue_pkg::XLEN-1:0]      wb_master_wdata_o,
    output logic                                 wb_slave_wen_o,
    output logic [dual_issue_pkg::REG_AW-1:0]    wb_slave_waddr_o,
    output logic [dual_issue_pkg::XLEN-1:0]      wb_slave_wdata_o
);

    // lane 0 is the master, lane 1 the slave
    dual_issue_pkg::inst_u                   head [2];
    logic [dual_issue_pkg::FIFO_AW:0]        fifo_count;
    logic                                    fifo_full;
    logic [1:0]                              pop_cnt;

    logic [dual_issue_pkg::REG_AW-1:0]       d_rs        [2];
    logic [dual_issue_pkg::REG_AW-1:0]       d_rt        [2];
    logic [dual_issue_pkg::REG_AW-1:0]       d_waddr     [2];
    logic                                    d_wen       [2];
    logic [dual_issue_pkg::ALU_OP_W-1:0]     d_aluop     [2];
    logic                                    d_sel_shamt [2];
    logic                                    d_sel_imm   [2];
    logic [dual_issue_pkg::XLEN-1:0]         d_imm       [2];
    logic [4:0]                              d_shamt     [2];
    logic                                    d_issue     [2];
    logic [dual_issue_pkg::XLEN-1:0]         d_rf_rs     [2];
    logic [dual_issue_pkg::XLEN-1:0]         d_rf_rt     [2];
    logic [dual_issue_pkg::XLEN-1:0]         d_rs_val    [2];
    logic [dual_issue_pkg::XLEN-1:0]         d_rt_val    [2];

    logic                                    e_valid     [2];
    logic [dual_issue_pkg::ALU_OP_W-1:0]     e_aluop     [2];
    logic [dual_issue_pkg::XLEN-1:0]         e_a         [2];
    logic [dual_issue_pkg::XLEN-1:0]         e_b         [2];
    logic                                    e_wen       [2];
    logic [dual_issue_pkg::REG_AW-1:0]       e_waddr     [2];
    logic [dual_issue_pkg::XLEN-1:0]         e_res       [2];

    logic                                    w_wen       [2];
    logic [dual_issue_pkg::REG_AW-1:0]       w_waddr     [2];
    logic [dual_issue_pkg::XLEN-1:0]         w_res       [2];

    assign inst_ready_o = !fifo_full;

    inst_fifo u_inst_fifo (
        .clk         (clk),
        .rst_i       (rst_i),
        .push_i      (inst_valid_i && !fifo_full),
        .push_data_i (inst_i),
        .pop_cnt_i   (pop_cnt),
        .head0_o     (head[0]),
        .head1_o     (head[1]),
        .count_o     (fifo_count),
        .full_o      (fifo_full)
    );

    decoder u_decoder_master (
        .inst_i      (head[0]),
        .rs_o        (d_rs[0]),
        .rt_o        (d_rt[0]),
        .waddr_o     (d_waddr[0]),
        .wen_o       (d_wen[0]),
        .aluop_o     (d_aluop[0]),
        .sel_shamt_o (d_sel_shamt[0]),
        .sel_imm_o   (d_sel_imm[0]),
        .imm_o       (d_imm[0]),
        .shamt_o     (d_shamt[0])
    );

    decoder u_decoder_slave (
        .inst_i      (head[1]),
        .rs_o        (d_rs[1]),
        .rt_o        (d_rt[1]),
        .waddr_o     (d_waddr[1]),
        .wen_o       (d_wen[1]),
        .aluop_o     (d_aluop[1]),
        .sel_shamt_o (d_sel_shamt[1]),
        .sel_imm_o   (d_sel_imm[1]),
        .imm_o       (d_imm[1]),
        .shamt_o     (d_shamt[1])
    );

    issue_ctrl u_issue_ctrl (
        .count_i        (fifo_count),
        .master_wen_i   (d_wen[0]),
        .master_waddr_i (d_waddr[0]),
        .slave_rs_i     (d_rs[1]),
        .slave_rt_i     (d_rt[1]),
        .master_issue_o (d_issue[0]),
        .slave_issue_o  (d_issue[1]),
        .pop_cnt_o      (pop_cnt)
    );

    regfile u_regfile (
        .clk   (clk),
        .rst_i (rst_i),
        .ra0_i (d_rs[0]),
        .ra1_i (d_rt[0]),
        .ra2_i (d_rs[1]),
        .ra3_i (d_rt[1]),
        .we0_i (w_wen[0]),
        .wa0_i (w_waddr[0]),
        .wd0_i (w_res[0]),
        .we1_i (w_wen[1]),
        .wa1_i (w_waddr[1]),
        .wd1_i (w_res[1]),
        .rd0_o (d_rf_rs[0]),
        .rd1_o (d_rf_rt[0]),
        .rd2_o (d_rf_rs[1]),
        .rd3_o (d_rf_rt[1])
    );

    forward_unit u_forward_unit (
        .src0_i           (d_rs[0]),
        .src1_i           (d_rt[0]),
        .src2_i           (d_rs[1]),
        .src3_i           (d_rt[1]),
        .rf0_i            (d_rf_rs[0]),
        .rf1_i            (d_rf_rt[0]),
        .rf2_i            (d_rf_rs[1]),
        .rf3_i            (d_rf_rt[1]),
        .e_master_wen_i   (e_valid[0] && e_wen[0]),
        .e_master_waddr_i (e_waddr[0]),
        .e_master_res_i   (e_res[0]),
        .e_slave_wen_i    (e_valid[1] && e_wen[1]),
        .e_slave_waddr_i  (e_waddr[1]),
        .e_slave_res_i    (e_res[1]),
        .w_master_wen_i   (w_wen[0]),
        .w_master_waddr_i (w_waddr[0]),
        .w_master_res_i   (w_res[0]),
        .w_slave_wen_i    (w_wen[1]),
        .w_slave_waddr_i  (w_waddr[1]),
        .w_slave_res_i    (w_res[1]),
        .val0_o           (d_rs_val[0]),
        .val1_o           (d_rt_val[0]),
        .val2_o           (d_rs_val[1]),
        .val3_o           (d_rt_val[1])
    );

    // control bits of both stages
    always_ff @(posedge clk) begin
        for (int l = 0; l < 2; l++) begin
            if (rst_i) begin
                e_valid[l] <= 1'b0;
                w_wen[l]   <= 1'b0;
            end else begin
                e_valid[l] <= d_issue[l];
                w_wen[l]   <= e_valid[l] && e_wen[l];
            end
        end
    end

    // operands are selected before the D/E register
    always_ff @(posedge clk) begin
        for (int l = 0; l < 2; l++) begin
            e_aluop[l] <= d_aluop[l];
            e_a[l]     <= d_sel_shamt[l] ? dual_issue_pkg::XLEN'(d_shamt[l]) : d_rs_val[l];
            e_b[l]     <= d_sel_imm[l] ? d_imm[l] : d_rt_val[l];
            e_wen[l]   <= d_wen[l];
            e_waddr[l] <= d_waddr[l];
            w_waddr[l] <= e_waddr[l];
            w_res[l]   <= e_res[l];
        end
    end

    alu u_alu_master (
        .aluop_i (e_aluop[0]),
        .a_i     (e_a[0]),
        .b_i     (e_b[0]),
        .y_o     (e_res[0])
    );

    alu u_alu_slave (
        .aluop_i (e_aluop[1]),
        .a_i     (e_a[1]),
        .b_i     (e_b[1]),
        .y_o     (e_res[1])
    );

    assign wb_master_wen_o   = w_wen[0];
    assign wb_master_waddr_o = w_waddr[0];
    assign wb_master_wdata_o = w_res[0];
    assign wb_slave_wen_o    = w_wen[1];
    assign wb_slave_waddr_o  = w_waddr[1];
    assign wb_slave_wdata_o  = w_res[1];

endmodule

`default_nettype wire

// ==== tests/datapath_assert.sv ====
`default_nettype none

module datapath_assert (
    input wire                                  clk,
    input wire                                  rst_i,
    input wire                                  ready_i,
    input wire                                  master_wen_i,
    input wire  [dual_issue_pkg::REG_AW-1:0]    master_waddr_i,
    input wire                                  slave_wen_i,
    input wire  [dual_issue_pkg::REG_AW-1:0]    slave_waddr_i
);

    // pipeline comes out of reset empty
    wen_low_after_reset: assert property (@(posedge clk)
        rst_i |=> (!master_wen_i && !slave_wen_i))
        else $error("write enable high in the cycle after reset");

    master_waddr_nonzero: assert property (@(posedge clk)
        master_wen_i |-> (master_waddr_i != '0))
        else $error("master write-back targets register 0");

    slave_waddr_nonzero: assert property (@(posedge clk)
        slave_wen_i |-> (slave_waddr_i != '0))
        else $error("slave write-back targets register 0");

    ready_after_reset: assert property (@(posedge clk)
        $fell(rst_i) |-> ready_i)
        else $error("instruction queue not ready after reset");

endmodule

bind datapath datapath_assert u_datapath_assert (
    .clk            (clk),
    .rst_i          (rst_i),
    .ready_i        (inst_ready_o),
    .master_wen_i   (wb_master_wen_o),
    .master_waddr_i (wb_master_waddr_o),
    .slave_wen_i    (wb_slave_wen_o),
    .slave_waddr_i  (wb_slave_waddr_o)
);

`default_nettype wire

// ==== tests/tb_datapath.sv ====
`default_nettype none

module tb_datapath;

    localparam int NUM_WORDS   = 400;
    localparam int DRAIN_CYCLES = 20;
    localparam int CYCLE_LIMIT = NUM_WORDS * 4 + 200;

    logic                                    clk;
    logic                                    rst_i;
    logic                                    inst_valid_i;
    logic [dual_issue_pkg::XLEN-1:0]         inst_i;
    logic                                    inst_ready_o;
    logic                                    wb_master_wen_o;
    logic [dual_issue_pkg::REG_AW-1:0]       wb_master_waddr_o;
    logic [dual_issue_pkg::XLEN-1:0]         wb_master_wdata_o;
    logic                                    wb_slave_wen_o;
    logic [dual_issue_pkg::REG_AW-1:0]       wb_slave_waddr_o;
    logic [dual_issue_pkg::XLEN-1:0]         wb_slave_wdata_o;

    integer                                  seed = 32'h023b_0589;
    int                                      burst_left = 0;
    int                                      cycle_count = 0;
    logic [dual_issue_pkg::XLEN-1:0]         model_regs [dual_issue_pkg::REG_NUM];
    logic [dual_issue_pkg::REG_AW-1:0]       exp_addr [$];
    logic [dual_issue_pkg::XLEN-1:0]         exp_data [$];

    datapath dut (
        .clk               (clk),
        .rst_i             (rst_i),
        .inst_valid_i      (inst_valid_i),
        .inst_i            (inst_i),
        .inst_ready_o      (inst_ready_o),
        .wb_master_wen_o   (wb_master_wen_o),
        .wb_master_waddr_o (wb_master_waddr_o),
        .wb_master_wdata_o (wb_master_wdata_o),
        .wb_slave_wen_o    (wb_slave_wen_o),
        .wb_slave_waddr_o  (wb_slave_waddr_o),
        .wb_slave_wdata_o  (wb_slave_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    // one write-back port against the oldest pending write
    task automatic check_lane(input string lane, input logic wen,
                              input logic [dual_issue_pkg::REG_AW-1:0] waddr,
                              input logic [dual_issue_pkg::XLEN-1:0] wdata);
        logic [dual_issue_pkg::REG_AW-1:0] want_addr;
        logic [dual_issue_pkg::XLEN-1:0]   want_data;
        if (wen) begin
            if (exp_addr.size() == 0) begin
                $display("error: %s wrote register %0d but no write was pending", lane, waddr);
                $display("SOME TESTS FAILED");
                $fatal(1, "unexpected write-back");
            end else begin
                want_addr = exp_addr.pop_front();
                want_data = exp_data.pop_front();
                check_value({lane, "_waddr_o"}, 32'(waddr), 32'(want_addr));
                check_value({lane, "_wdata_o"}, wdata, want_data);
            end
        end
    endtask

    // master is older, so it is checked first
    always @(negedge clk) begin
        check_lane("wb_master", wb_master_wen_o, wb_master_waddr_o, wb_master_wdata_o);
        check_lane("wb_slave", wb_slave_wen_o, wb_slave_waddr_o, wb_slave_wdata_o);
    end

    task automatic make_inst(output dual_issue_pkg::inst_u w);
        int sel;
        w = $random(seed);
        w.r.rs = 5'({$random(seed)} % 8);
        w.r.rt = 5'({$random(seed)} % 8);
        w.r.rd = 5'({$random(seed)} % 8);
        if ({$random(seed)} % 100 < 5) begin
            // opcodes 0x20..0x2f lie outside the subset
            w.r.op = 6'h20 | 6'({$random(seed)} % 16);
        end else begin
            sel = {$random(seed)} % 17;
            w.r.op = dual_issue_pkg::OP_RTYPE;
            case (sel)
                0:  w.r.funct = dual_issue_pkg::FN_ADDU;
                1:  w.r.funct = dual_issue_pkg::FN_SUBU;
                2:  w.r.funct = dual_issue_pkg::FN_AND;
                3:  w.r.funct = dual_issue_pkg::FN_OR;
                4:  w.r.funct = dual_issue_pkg::FN_XOR;
                5:  w.r.funct = dual_issue_pkg::FN_NOR;
                6:  w.r.funct = dual_issue_pkg::FN_SLT;
                7:  w.r.funct = dual_issue_pkg::FN_SLTU;
                8:  w.r.funct = dual_issue_pkg::FN_SLL;
                9:  w.r.funct = dual_issue_pkg::FN_SRL;
                10: w.r.funct = dual_issue_pkg::FN_SRA;
                11: w.i.op = dual_issue_pkg::OP_ADDIU;
                12: w.i.op = dual_issue_pkg::OP_SLTI;
                13: w.i.op = dual_issue_pkg::OP_ANDI;
                14: w.i.op = dual_issue_pkg::OP_ORI;
                15: w.i.op = dual_issue_pkg::OP_XORI;
                default: w.i.op = dual_issue_pkg::OP_LUI;
            endcase
            if (w.i.op != dual_issue_pkg::OP_RTYPE) begin
                // full 16-bit immediate, negative values included
                w.i.imm16 = 16'($random(seed));
            end
        end
    endtask

    // sequential reference: one instruction at a time, in program order
    task automatic model_step(input dual_issue_pkg::inst_u w);
        logic [31:0] rs_v;
        logic [31:0] rt_v;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [31:0] res;
        logic [4:0]  dest;
        logic        known;
        rs_v  = model_regs[w.r.rs];
        rt_v  = model_regs[w.r.rt];
        simm  = {{16{w.i.imm16[15]}}, w.i.imm16};
        zimm  = {16'h0000, w.i.imm16};
        res   = '0;
        known = 1'b1;
        if (w.r.op == dual_issue_pkg::OP_RTYPE) begin
            dest = w.r.rd;
            case (w.r.funct)
                dual_issue_pkg::FN_ADDU: res = rs_v + rt_v;
                dual_issue_pkg::FN_SUBU: res = rs_v - rt_v;
                dual_issue_pkg::FN_AND:  res = rs_v & rt_v;
                dual_issue_pkg::FN_OR:   res = rs_v | rt_v;
                dual_issue_pkg::FN_XOR:  res = rs_v ^ rt_v;
                dual_issue_pkg::FN_NOR:  res = ~(rs_v | rt_v);
                dual_issue_pkg::FN_SLT:  res = ($signed(rs_v) < $signed(rt_v)) ? 32'd1 : 32'd0;
                dual_issue_pkg::FN_SLTU: res = (rs_v < rt_v) ? 32'd1 : 32'd0;
                dual_issue_pkg::FN_SLL:  res = rt_v << w.r.shamt;
                dual_issue_pkg::FN_SRL:  res = rt_v >> w.r.shamt;
                dual_issue_pkg::FN_SRA:  res = $signed(rt_v) >>> w.r.shamt;
                default:                 known = 1'b0;
            endcase
        end else begin
            dest = w.i.rt;
            case (w.i.op)
                dual_issue_pkg::OP_ADDIU: res = rs_v + simm;
                dual_issue_pkg::OP_SLTI:  res = ($signed(rs_v) < $signed(simm)) ? 32'd1 : 32'd0;
                dual_issue_pkg::OP_ANDI:  res = rs_v & zimm;
                dual_issue_pkg::OP_ORI:   res = rs_v | zimm;
                dual_issue_pkg::OP_XORI:  res = rs_v ^ zimm;
                dual_issue_pkg::OP_LUI:   res = {w.i.imm16, 16'h0000};
                default:                  known = 1'b0;
            endcase
        end
        if (known && dest != 5'd0) begin
            model_regs[dest] = res;
            exp_addr.push_back(dest);
            exp_data.push_back(res);
        end
    endtask

    // random gaps, with an occasional long burst
    task automatic pick_valid(output logic v);
        if (burst_left > 0) begin
            burst_left--;
            v = 1'b1;
        end else if ({$random(seed)} % 32 == 0) begin
            burst_left = 24;
            v = 1'b1;
        end else begin
            v = ({$random(seed)} % 4 != 0);
        end
    endtask

    initial begin
        dual_issue_pkg::inst_u word;
        logic                  v;
        logic                  accepted;
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        for (int r = 0; r < dual_issue_pkg::REG_NUM; r++) begin
            model_regs[r] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_i = 1'b0;
        for (int n = 0; n < NUM_WORDS; n++) begin
            make_inst(word);
            accepted = 1'b0;
            while (!accepted) begin
                pick_valid(v);
                inst_valid_i = v;
                inst_i       = v ? word : $random(seed);
                @(negedge clk);
                accepted = inst_valid_i && inst_ready_o;
                @(posedge clk);
                #1;
            end
            model_step(word);
        end
        inst_valid_i = 1'b0;
        repeat (DRAIN_CYCLES) @(posedge clk);
        if (exp_addr.size() != 0) begin
            $display("error: %0d expected writes never reached write-back", exp_addr.size());
            $display("SOME TESTS FAILED");
            $fatal(1, "writes lost");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/dual_issue_pkg.sv
hdl/inst_fifo.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/forward_unit.sv
hdl/issue_ctrl.sv
hdl/alu.sv
hdl/datapath.sv
tests/datapath_assert.sv
tests/tb_datapath.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing
TOP       ?= tb_datapath
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := SOME TESTS FAILED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
